//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_llki_pp
FILELIST  = files.f
OBJDIR    = obj_dir
PASS_MSG  = Simulation finished: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

//--- files.f
+incdir+.
llki_pkg.sv
llki_reg_decode.sv
llki_msg_fsm.sv
llki_resp_port.sv
llki_pp_top.sv
tb_llki_pp.sv

//--- llki_msg_fsm.sv
// Host must poll ready-for-key between key words; words arriving outside idle or load are dropped
`timescale 1ns/10ps
`default_nettype none

`include "llki_settings.svh"

module llki_msg_fsm import llki_pkg::*; (
  input  wire                 clk,
  input  wire                 rst,
  // From register decode
  input  wire                 sr_wr_i,
  input  wire llki_word_u     sr_wdata_i,
  // Key sink levels
  input  wire                 key_ready_i,
  input  wire                 key_complete_i,
  input  wire                 clear_key_ack_i,
  // From response port
  input  wire                 resp_pending_i,
  // Key sink drive
  output logic [`LLKI_DW-1:0] key_data_o,
  output logic                key_valid_o,
  output logic                clear_key_o,
  // Response toward the response port
  output logic                resp_post_o,
  output llki_word_u          resp_word_o
);

  llki_state_e state_q;
  llki_state_e state_d;
  llki_hdr_t   hdr_q;
  llki_hdr_t   hdr_d;
  logic        clear_d;
  logic        key_accept;
  logic        post_now;
  logic [7:0]  post_id;
  logic [7:0]  post_st;

  // Length field is filled in by the response port
  function automatic llki_word_u mk_resp(input logic [7:0] id, input logic [7:0] st);
    llki_word_u w;
    w            = '0;
    w.hdr.msg_id = id;
    w.hdr.status = st;
    return w;
  endfunction

  // ----------------------------------------
  // Next state and decisions
  // ----------------------------------------
  always_comb begin
    state_d    = state_q;
    hdr_d      = hdr_q;
    clear_d    = clear_key_o;
    key_accept = 1'b0;
    post_now   = 1'b0;
    post_id    = `LLKI_MID_ERRORRESP;
    post_st    = `LLKI_ST_GOOD;
    case (state_q)
      st_idle: begin
        if (sr_wr_i) begin
          hdr_d   = sr_wdata_i.hdr;
          state_d = st_check;
        end
      end
      st_check: begin
        case (hdr_q.msg_id)
          `LLKI_MID_LOADKEYREQ: begin
            // Header alone carries no key
            if (hdr_q.msg_len <= 16'd1) begin
              post_now = 1'b1;
              post_st  = `LLKI_ST_BAD_MSG_LEN;
            end else if (key_complete_i) begin
              post_now = 1'b1;
              post_st  = `LLKI_ST_KEY_OVERWRITE;
            end else begin
              state_d = st_load_key;
            end
          end
          `LLKI_MID_CLEARKEYREQ: begin
            if (hdr_q.msg_len != 16'd1) begin
              post_now = 1'b1;
              post_st  = `LLKI_ST_BAD_MSG_LEN;
            end else begin
              clear_d = 1'b1;
              state_d = st_clear_key;
            end
          end
          `LLKI_MID_KEYSTATUSREQ: begin
            post_now = 1'b1;
            if (hdr_q.msg_len != 16'd1) begin
              post_st = `LLKI_ST_BAD_MSG_LEN;
            end else begin
              post_id = `LLKI_MID_KEYSTATUSRESP;
              post_st = key_complete_i ? `LLKI_ST_KEY_PRESENT : `LLKI_ST_KEY_NOT_PRESENT;
            end
          end
          default: begin
            post_now = 1'b1;
            post_st  = `LLKI_ST_BAD_MSG_ID;
          end
        endcase
      end
      st_load_key: begin
        if (sr_wr_i) begin
          if (!key_ready_i) begin
            // Word is dropped, host lost track of ready
            post_now = 1'b1;
            post_st  = `LLKI_ST_LOSS_OF_SYNC;
          end else if (key_complete_i) begin
            // Too many words for this core, wipe it first
            hdr_d.msg_id = `LLKI_MID_ERRORRESP;
            hdr_d.status = `LLKI_ST_BAD_KEY_LEN;
            clear_d      = 1'b1;
            state_d      = st_clear_key;
          end else begin
            key_accept = 1'b1;
            // Length still counts the header, so 2 marks the last word
            if (hdr_q.msg_len == 16'd2) begin
              state_d = st_wait_complete;
            end else begin
              hdr_d.msg_len = hdr_q.msg_len - 16'd1;
            end
          end
        end
      end
      st_wait_complete: begin
        if (key_complete_i) begin
          post_now = 1'b1;
          post_id  = `LLKI_MID_LOADKEYACK;
        end
      end
      st_clear_key: begin
        if (clear_key_ack_i) begin
          clear_d  = 1'b0;
          post_now = 1'b1;
          // Error from the load path keeps its own code
          if (hdr_q.msg_id == `LLKI_MID_ERRORRESP) begin
            post_st = hdr_q.status;
          end else begin
            post_id = `LLKI_MID_CLEARKEYACK;
          end
        end
      end
      st_wait_read: begin
        // Pending only rises the edge after the post
        if (!resp_pending_i && !resp_post_o) begin
          state_d = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
    if (post_now) begin
      state_d = st_wait_read;
    end
  end

  // ----------------------------------------
  // Control registers
  // ----------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q     <= st_idle;
      hdr_q       <= '0;
      clear_key_o <= 1'b0;
      key_valid_o <= 1'b0;
      resp_post_o <= 1'b0;
    end else begin
      state_q     <= state_d;
      hdr_q       <= hdr_d;
      clear_key_o <= clear_d;
      key_valid_o <= key_accept;
      resp_post_o <= post_now;
    end
  end

  // Payload, only meaningful alongside its strobe
  always_ff @(posedge clk) begin
    if (key_accept) begin
      key_data_o <= sr_wdata_i.raw;
    end
    if (post_now) begin
      resp_word_o <= mk_resp(post_id, post_st);
    end
  end

  a_key_vs_clear : assert property (@(posedge clk) disable iff (rst)
    !(key_valid_o && clear_key_o))
    else $error("key word pushed during clear-key");

endmodule

`default_nettype wire

//--- llki_patterns.txt
# Columns: W addr wdata err | R addr rdata err | K ready words_until_complete (0 = never)
# P polls for a response, E checks next key word, C checks clear-key count, T starts a test
T unmapped_access
K 0 0
W 00000010 12345678 1
R 00000004 00000000 1
R 00000000 00000000 0
W 00000000 deadbeef 0
R 00000000 00000000 0
T status_before_load
W 00000008 00010002 0
P
R 00000000 00000002 0
R 00000008 00010205 0
R 00000000 00000000 0
T load_key
K 1 2
R 00000000 00000001 0
W 00000008 00030000 0
W 00000008 11111111 0
W 00000008 22222222 0
P
E 11111111
E 22222222
R 00000008 00010003 0
R 00000008 00000000 0
T status_after_load
W 00000008 00010002 0
P
R 00000008 00010105 0
W 00000008 00020002 0
P
R 00000008 00012106 0
T key_overwrite
W 00000008 00030000 0
P
R 00000008 00012206 0
T clear_key
W 00000008 00010001 0
P
C 1
R 00000008 00010004 0
W 00000008 00010002 0
P
R 00000008 00010205 0
T bad_msg_id
W 00000008 00010009 0
P
R 00000008 00012006 0
T loss_of_sync
K 0 0
W 00000008 00030000 0
W 00000008 33333333 0
P
R 00000008 00012406 0
R 00000000 00000000 0
T bad_key_len
K 1 2
W 00000008 00040000 0
W 00000008 44444444 0
W 00000008 55555555 0
W 00000008 66666666 0
P
E 44444444
E 55555555
C 1
R 00000008 00012306 0
R 00000000 00000001 0

//--- llki_pkg.sv
// The header/key union only lines up when LLKI_DW is 32, matching the 16+8+8 header split
`default_nettype none

`include "llki_settings.svh"

package llki_pkg;

  // ----------------------------------------
  // Message header
  // ----------------------------------------
  // Length counts the header itself, so a bare request has length 1
  typedef struct packed {
    logic [15:0] msg_len;
    logic [7:0]  status;
    logic [7:0]  msg_id;
  } llki_hdr_t;

  // ----------------------------------------
  // Send/receive word
  // ----------------------------------------
  // Same bus word seen as a header in idle
  // and as raw key material during a load
  typedef union packed {
    llki_hdr_t             hdr;
    logic [`LLKI_DW-1:0]   raw;
  } llki_word_u;

  // ----------------------------------------
  // Message FSM states
  // ----------------------------------------
  typedef enum logic [2:0] {
    // Waiting for a request header
    st_idle,
    // Header captured, checking id and length
    st_check,
    // Forwarding key words to the core
    st_load_key,
    // Last word sent, waiting for the core
    st_wait_complete,
    // Clear-key handshake in progress
    st_clear_key,
    // Response posted, waiting for host read
    st_wait_read
  } llki_state_e;

endpackage

`default_nettype wire

//--- llki_pp_top.sv
// Register addresses must differ per core; key words are one bus word, accesses whole words
`timescale 1ns/10ps
`default_nettype none

`include "llki_settings.svh"

module llki_pp_top import llki_pkg::*; #(
  parameter logic [`LLKI_AW-1:0] ctrlsts_addr  = `LLKI_CTRLSTS_ADDR,
  parameter logic [`LLKI_AW-1:0] sendrecv_addr = `LLKI_SENDRECV_ADDR
) (
  input  wire                 clk,
  input  wire                 rst,
  // Host register port
  input  wire                 reg_we_i,
  input  wire                 reg_re_i,
  input  wire [`LLKI_AW-1:0]  reg_addr_i,
  input  wire [`LLKI_DW-1:0]  reg_wdata_i,
  output logic                reg_ack_o,
  output logic                reg_err_o,
  output logic [`LLKI_DW-1:0] reg_rdata_o,
  // Key sink
  output logic [`LLKI_DW-1:0] key_data_o,
  output logic                key_valid_o,
  input  wire                 key_ready_i,
  input  wire                 key_complete_i,
  output logic                clear_key_o,
  input  wire                 clear_key_ack_i
);

  logic       sr_wr;
  logic       sr_rd;
  logic       cs_rd;
  llki_word_u sr_wdata;
  logic       resp_post;
  llki_word_u resp_word;
  logic       resp_pending;

  // ----------------------------------------
  // Input side
  // ----------------------------------------
  llki_reg_decode #(
    .ctrlsts_addr  (ctrlsts_addr),
    .sendrecv_addr (sendrecv_addr)
  ) u_reg_decode (
    .clk         (clk),
    .rst         (rst),
    .reg_we_i    (reg_we_i),
    .reg_re_i    (reg_re_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .sr_wr_o     (sr_wr),
    .sr_rd_o     (sr_rd),
    .cs_rd_o     (cs_rd),
    .sr_wdata_o  (sr_wdata),
    .reg_ack_o   (reg_ack_o),
    .reg_err_o   (reg_err_o)
  );

  // Message processing
  llki_msg_fsm u_msg_fsm (
    .clk             (clk),
    .rst             (rst),
    .sr_wr_i         (sr_wr),
    .sr_wdata_i      (sr_wdata),
    .key_ready_i     (key_ready_i),
    .key_complete_i  (key_complete_i),
    .clear_key_ack_i (clear_key_ack_i),
    .resp_pending_i  (resp_pending),
    .key_data_o      (key_data_o),
    .key_valid_o     (key_valid_o),
    .clear_key_o     (clear_key_o),
    .resp_post_o     (resp_post),
    .resp_word_o     (resp_word)
  );

  // ----------------------------------------
  // Output side
  // ----------------------------------------
  llki_resp_port u_resp_port (
    .clk            (clk),
    .rst            (rst),
    .resp_post_i    (resp_post),
    .resp_word_i    (resp_word),
    .sr_rd_i        (sr_rd),
    .cs_rd_i        (cs_rd),
    .key_ready_i    (key_ready_i),
    .resp_pending_o (resp_pending),
    .reg_rdata_o    (reg_rdata_o)
  );

endmodule

`default_nettype wire

//--- llki_reg_decode.sv
// Whole-word accesses only; a write and a read strobe must never share a cycle
`timescale 1ns/10ps
`default_nettype none

`include "llki_settings.svh"

module llki_reg_decode import llki_pkg::*; #(
  parameter logic [`LLKI_AW-1:0] ctrlsts_addr  = `LLKI_CTRLSTS_ADDR,
  parameter logic [`LLKI_AW-1:0] sendrecv_addr = `LLKI_SENDRECV_ADDR
) (
  input  wire                 clk,
  input  wire                 rst,
  // Host register port
  input  wire                 reg_we_i,
  input  wire                 reg_re_i,
  input  wire [`LLKI_AW-1:0]  reg_addr_i,
  input  wire [`LLKI_DW-1:0]  reg_wdata_i,
  // Decoded pulses toward the FSM and response port
  output logic                sr_wr_o,
  output logic                sr_rd_o,
  output logic                cs_rd_o,
  output llki_word_u          sr_wdata_o,
  // Host reply
  output logic                reg_ack_o,
  output logic                reg_err_o
);

  logic cs_hit;
  logic sr_hit;
  logic access;

  // ----------------------------------------
  // Address compare
  // ----------------------------------------
  assign cs_hit = (reg_addr_i == ctrlsts_addr);
  assign sr_hit = (reg_addr_i == sendrecv_addr);
  assign access = reg_we_i | reg_re_i;

  // Same-cycle pulses, no latency added here
  assign sr_wr_o = reg_we_i & sr_hit;
  assign sr_rd_o = reg_re_i & sr_hit;
  assign cs_rd_o = reg_re_i & cs_hit;

  // Header or key word, the FSM picks the view
  assign sr_wdata_o = llki_word_u'(reg_wdata_i);

  // ----------------------------------------
  // Acknowledge and error
  // ----------------------------------------
  // Writes to control/status are accepted and ignored
  // Anything off the two addresses errors in the ack cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      reg_ack_o <= 1'b0;
      reg_err_o <= 1'b0;
    end else begin
      reg_ack_o <= access;
      reg_err_o <= access & ~(cs_hit | sr_hit);
    end
  end

  // Host side must serialize accesses
  a_one_strobe : assert property (@(posedge clk) disable iff (rst)
    !(reg_we_i && reg_re_i))
    else $error("register write and read strobes in the same cycle");

endmodule

`default_nettype wire

//--- llki_resp_port.sv
// One response slot, no FIFO; a new post must wait until the host has read the last one
`timescale 1ns/10ps
`default_nettype none

`include "llki_settings.svh"

module llki_resp_port import llki_pkg::*; (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 resp_post_i,
  input  wire llki_word_u     resp_word_i,
  input  wire                 sr_rd_i,
  input  wire                 cs_rd_i,
  input  wire                 key_ready_i,
  output logic                resp_pending_o,
  output logic [`LLKI_DW-1:0] reg_rdata_o
);

  llki_word_u          resp_q;
  logic                ready_q;
  logic                waiting_q;
  logic [`LLKI_DW-1:0] cs_word;

  // ----------------------------------------
  // Response slot
  // ----------------------------------------
  // Every response is a single header word
  always_ff @(posedge clk) begin
    if (resp_post_i) begin
      resp_q             <= resp_word_i;
      resp_q.hdr.msg_len <= 16'd1;
    end else if (sr_rd_i) begin
      resp_q <= '0;
    end
  end

  // Status bits lag their sources by one cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      resp_pending_o <= 1'b0;
      ready_q        <= 1'b0;
      waiting_q      <= 1'b0;
    end else begin
      if (resp_post_i) begin
        resp_pending_o <= 1'b1;
      end else if (sr_rd_i) begin
        resp_pending_o <= 1'b0;
      end
      ready_q   <= key_ready_i;
      waiting_q <= resp_pending_o;
    end
  end

  // ----------------------------------------
  // Read-back
  // ----------------------------------------
  always_comb begin
    cs_word                        = '0;
    cs_word[`LLKI_STS_READY_BIT]   = ready_q;
    cs_word[`LLKI_STS_WAITING_BIT] = waiting_q;
  end

  // Zero outside the ack cycle, and on an empty slot
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      reg_rdata_o <= '0;
    end else if (cs_rd_i) begin
      reg_rdata_o <= cs_word;
    end else if (sr_rd_i && resp_pending_o) begin
      reg_rdata_o <= resp_q.raw;
    end else begin
      reg_rdata_o <= '0;
    end
  end

  // FSM must sit in wait-read until the slot empties
  a_no_overrun : assert property (@(posedge clk) disable iff (rst)
    resp_post_i |-> !resp_pending_o)
    else $error("response posted over an unread one");

endmodule

`default_nettype wire

//--- llki_settings.svh
// Widths assume one 32-bit word for bus, key and header; default addresses suit a single core only
`ifndef LLKI_SETTINGS_SVH
`define LLKI_SETTINGS_SVH

// ----------------------------------------
// Widths and register map
// ----------------------------------------
`define LLKI_DW                 32
`define LLKI_AW                 32
`define LLKI_CTRLSTS_ADDR       32'h0000_0000
`define LLKI_SENDRECV_ADDR      32'h0000_0008

// Control/status bit positions
`define LLKI_STS_READY_BIT      0
`define LLKI_STS_WAITING_BIT    1

// ----------------------------------------
// Message ids
// ----------------------------------------
`define LLKI_MID_LOADKEYREQ     8'h00
`define LLKI_MID_CLEARKEYREQ    8'h01
`define LLKI_MID_KEYSTATUSREQ   8'h02
`define LLKI_MID_LOADKEYACK     8'h03
`define LLKI_MID_CLEARKEYACK    8'h04
`define LLKI_MID_KEYSTATUSRESP  8'h05
`define LLKI_MID_ERRORRESP      8'h06

// Status codes carried in the response header
`define LLKI_ST_GOOD            8'h00
`define LLKI_ST_KEY_PRESENT     8'h01
`define LLKI_ST_KEY_NOT_PRESENT 8'h02
`define LLKI_ST_BAD_MSG_ID      8'h20
`define LLKI_ST_BAD_MSG_LEN     8'h21
`define LLKI_ST_KEY_OVERWRITE   8'h22
`define LLKI_ST_BAD_KEY_LEN     8'h23
`define LLKI_ST_LOSS_OF_SYNC    8'h24

`endif

//--- tb_llki_pp.sv
// Run from the project root so llki_patterns.txt is found; assumes the default register addresses
`timescale 1ns/10ps
`default_nettype none

`include "llki_settings.svh"

module tb_llki_pp;

  localparam int ACK_LIMIT       = 20;
  localparam int POLL_LIMIT      = 50;
  localparam int CYCLES_PER_LINE = 200;

  logic                clk;
  logic                rst;
  logic                reg_we_i;
  logic                reg_re_i;
  logic [`LLKI_AW-1:0] reg_addr_i;
  logic [`LLKI_DW-1:0] reg_wdata_i;
  logic                reg_ack_o;
  logic                reg_err_o;
  logic [`LLKI_DW-1:0] reg_rdata_o;
  logic [`LLKI_DW-1:0] key_data_o;
  logic                key_valid_o;
  logic                key_ready_i;
  logic                key_complete_i;
  logic                clear_key_o;
  logic                clear_key_ack_i;

  // Key sink model state
  logic [`LLKI_DW-1:0] key_q[$];
  int                  words_left;
  int                  clear_cnt;
  int                  ack_delay;
  logic                valid_prev;

  // Run bookkeeping
  string               lines[$];
  int                  limit_cycles;
  int                  errors;
  int                  test_errors;
  int                  tests_run;
  int                  tests_failed;
  string               test_name;

  llki_pp_top dut_i (
    .clk             (clk),
    .rst             (rst),
    .reg_we_i        (reg_we_i),
    .reg_re_i        (reg_re_i),
    .reg_addr_i      (reg_addr_i),
    .reg_wdata_i     (reg_wdata_i),
    .reg_ack_o       (reg_ack_o),
    .reg_err_o       (reg_err_o),
    .reg_rdata_o     (reg_rdata_o),
    .key_data_o      (key_data_o),
    .key_valid_o     (key_valid_o),
    .key_ready_i     (key_ready_i),
    .key_complete_i  (key_complete_i),
    .clear_key_o     (clear_key_o),
    .clear_key_ack_i (clear_key_ack_i)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------
  // Behavioral key sink
  // ----------------------------------------
  // Samples and drives 1 ns after the edge
  always @(posedge clk) begin
    #1;
    if (key_valid_o) begin
      if (valid_prev) begin
        $display("key_valid_o stayed high for two cycles at %0t ns", $time);
        flag_error();
      end
      key_q.push_back(key_data_o);
      // Core completes after the programmed number of words
      if (words_left > 0) begin
        words_left = words_left - 1;
        if (words_left == 0) begin
          key_complete_i = 1'b1;
        end
      end
    end
    valid_prev = key_valid_o;
    // Clear handshake acks two cycles after the request
    if (clear_key_ack_i && !clear_key_o) begin
      clear_key_ack_i = 1'b0;
    end else if (clear_key_o && !clear_key_ack_i) begin
      ack_delay = ack_delay + 1;
      if (ack_delay == 2) begin
        clear_key_ack_i = 1'b1;
        key_complete_i  = 1'b0;
        ack_delay       = 0;
        clear_cnt       = clear_cnt + 1;
      end
    end
  end

  // ----------------------------------------
  // Check helpers
  // ----------------------------------------
  task automatic flag_error();
    errors      = errors + 1;
    test_errors = test_errors + 1;
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
      flag_error();
    end
  endtask

  // One register access with a one-cycle strobe and a wait for the ack
  task automatic bus_access(input logic we, input logic [31:0] addr,
                            input logic [31:0] data, output logic [31:0] rdata,
                            output logic err);
    int waited;
    @(posedge clk);
    #1;
    reg_we_i    = we;
    reg_re_i    = ~we;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    @(posedge clk);
    #1;
    reg_we_i    = 1'b0;
    reg_re_i    = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    waited      = 0;
    while (!reg_ack_o && waited < ACK_LIMIT) begin
      @(posedge clk);
      #1;
      waited = waited + 1;
    end
    if (!reg_ack_o) begin
      $display("No acknowledge for the access to %h at %0t ns", addr, $time);
      flag_error();
    end else if (waited != 0) begin
      $display("Acknowledge for %h came %0d cycles late at %0t ns", addr, waited, $time);
      flag_error();
    end
    rdata = reg_rdata_o;
    err   = reg_err_o;
  endtask

  // Read control/status until the response-waiting bit shows
  task automatic poll_waiting();
    logic [31:0] rd;
    logic        err;
    logic        seen;
    int          tries;
    seen  = 1'b0;
    tries = 0;
    while (!seen && tries < POLL_LIMIT) begin
      bus_access(1'b0, `LLKI_CTRLSTS_ADDR, 32'h0, rd, err);
      // Status register is mapped, so no read may error
      check_word("reg_err_o", 32'(err), 32'h0);
      seen  = rd[`LLKI_STS_WAITING_BIT];
      tries = tries + 1;
    end
    if (!seen) begin
      $display("No response posted after %0d status reads at %0t ns", POLL_LIMIT, $time);
      flag_error();
    end
  endtask

  task automatic close_test();
    if (tests_run > 0) begin
      if (test_errors == 0) begin
        $display("Test %s: passed", test_name);
      end else begin
        $display("Test %s: failed with %0d errors", test_name, test_errors);
        tests_failed = tests_failed + 1;
      end
    end
  endtask

  // ----------------------------------------
  // Pattern interpreter
  // ----------------------------------------
  task automatic run_line(input string line);
    string       cmd;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp_err;
    logic [31:0] rdata;
    logic        err;
    int          lvl;
    int          cnt;
    int          n;
    n = $sscanf(line, "%s", cmd);
    if (n != 1 || cmd.getc(0) == "#") begin
      return;
    end
    if (cmd == "T") begin
      close_test();
      n           = $sscanf(line, "%s %s", cmd, test_name);
      tests_run   = tests_run + 1;
      test_errors = 0;
    end else if (cmd == "W" || cmd == "R") begin
      n = $sscanf(line, "%s %h %h %h", cmd, addr, data, exp_err);
      if (n != 4) begin
        $display("Malformed pattern line: %s", line);
        flag_error();
      end else if (cmd == "W") begin
        bus_access(1'b1, addr, data, rdata, err);
        check_word("reg_err_o", 32'(err), exp_err);
      end else begin
        bus_access(1'b0, addr, 32'h0, rdata, err);
        check_word("reg_rdata_o", rdata, data);
        check_word("reg_err_o", 32'(err), exp_err);
      end
    end else if (cmd == "P") begin
      poll_waiting();
    end else if (cmd == "K") begin
      n = $sscanf(line, "%s %d %d", cmd, lvl, cnt);
      @(posedge clk);
      #1;
      key_ready_i = (lvl != 0);
      words_left  = cnt;
    end else if (cmd == "E") begin
      n = $sscanf(line, "%s %h", cmd, data);
      if (key_q.size() == 0) begin
        $display("Expected key word %h but none was captured by %0t ns", data, $time);
        flag_error();
      end else begin
        check_word("key_data_o", key_q.pop_front(), data);
      end
    end else if (cmd == "C") begin
      n = $sscanf(line, "%s %d", cmd, cnt);
      check_word("clear_key_o handshakes", 32'(clear_cnt), 32'(cnt));
      clear_cnt = 0;
    end else begin
      $display("Unknown pattern command: %s", line);
      flag_error();
    end
  endtask

  // ----------------------------------------
  // Main run
  // ----------------------------------------
  initial begin : main_run
    int    fd;
    int    n;
    string line;
    rst             = 1'b1;
    reg_we_i        = 1'b0;
    reg_re_i        = 1'b0;
    reg_addr_i      = '0;
    reg_wdata_i     = '0;
    key_ready_i     = 1'b0;
    key_complete_i  = 1'b0;
    clear_key_ack_i = 1'b0;
    words_left      = 0;
    clear_cnt       = 0;
    ack_delay       = 0;
    valid_prev      = 1'b0;
    errors          = 0;
    test_errors     = 0;
    tests_run       = 0;
    tests_failed    = 0;
    test_name       = "";
    fd = $fopen("llki_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open llki_patterns.txt");
      errors = errors + 1;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0) begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
    end
    // Watchdog budget scales with the pattern length
    limit_cycles = (lines.size() + 1) * CYCLES_PER_LINE;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    foreach (lines[i]) begin
      run_line(lines[i]);
    end
    close_test();
    if (key_q.size() != 0) begin
      $display("%0d captured key words were never checked", key_q.size());
      errors = errors + 1;
    end
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Ends a stuck run
  initial begin : watchdog
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout, the pattern run did not finish within %0d cycles", limit_cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
